//--- l15_pkg.sv
package l15_pkg;

	// Field widths of the transducer to L1.5 request and response
	localparam int rqtype_w     = 5;
	localparam int rqsize_w     = 3;
	localparam int l15_addr_w   = 32;
	localparam int l15_data_w   = 64;
	localparam int returntype_w = 4;

	// Request side
	typedef logic [rqtype_w-1:0]   rqtype_t;    // Load, store, ifill ...
	typedef logic [rqsize_w-1:0]   rqsize_t;    // Byte count code
	typedef logic [l15_addr_w-1:0] l15_addr_t;  // Physical address

	// One 64 bit beat, used for store data and both response halves
	typedef logic [l15_data_w-1:0] l15_data_t;

	// Response side
	typedef logic [returntype_w-1:0] returntype_t;

endpackage

//--- arb_pkg.sv
package arb_pkg;

	localparam int arb_state_w = 2;

	// Who owns the single L1.5 port
	typedef enum logic [arb_state_w-1:0]
	{
		arb_instr = 2'd0,  // Fetch connected, no data request
		arb_wait  = 2'd1,  // Data request waiting for fetch to leave
		arb_mem   = 2'd2   // Data unit connected
	} arb_state_t;

	// Fetch owns the port out of reset
	localparam arb_state_t arb_reset_state = arb_instr;

endpackage

//--- l15_req_if.sv
`timescale 1ns/100ps

interface l15_req_if;
	import l15_pkg::*;

	rqtype_t   rqtype;
	rqsize_t   size;
	l15_addr_t address;
	l15_data_t data;
	logic      val;         // Held until ack or header_ack
	logic      ack;
	logic      header_ack;

	// Requesting side, fetch or data unit
	modport client (
		output rqtype, size, address, data, val,
		input  ack, header_ack
	);

	// Arbiter side of a client channel
	modport arbiter (
		input  rqtype, size, address, data, val,
		output ack, header_ack
	);

	// Channel toward the cache, driven like a client
	modport cache (
		output rqtype, size, address, data, val,
		input  ack, header_ack
	);

endinterface

//--- l15_resp_if.sv
`timescale 1ns/100ps

interface l15_resp_if;
	import l15_pkg::*;

	logic        val;         // One cycle strobe
	l15_data_t   data_0;
	l15_data_t   data_1;
	returntype_t returntype;
	logic        req_ack;     // Raised by the receiving client

	// Response source
	modport cache (
		output val, data_0, data_1, returntype,
		input  req_ack
	);

	// Response sink
	modport client (
		input  val, data_0, data_1, returntype,
		output req_ack
	);

endinterface

//--- arb_fsm.sv
`timescale 1ns/100ps

module arb_fsm (
	input  logic                clk,
	input  logic                nrst,
	input  logic                dmem_pending,      // Memory op sitting in issue
	input  logic                issue_hold,
	input  logic                fetch_resp_phase,  // Fetch expecting its response
	input  logic                mem_op_done,
	input  logic                cache_resp_val,
	input  logic                cache_ack,
	output arb_pkg::arb_state_t state,
	output logic                stall_mem,
	output logic                arb_eqmem,
	output logic                dmem_finished
);
	import arb_pkg::*;

	// stall_mem rises on the way into arb_wait and drops one cycle after
	// arb_mem is entered, arb_eqmem follows the same one cycle lag
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state     <= arb_reset_state;
			stall_mem <= 1'b0;
			arb_eqmem <= 1'b0;
		end
		else
		begin
			case (state)
				arb_instr:
				begin
					if (dmem_pending && !issue_hold)
					begin
						state     <= arb_wait;
						stall_mem <= 1'b1;
					end
				end
				arb_wait:
				begin
					// Let the outstanding fetch response drain first
					if (fetch_resp_phase && cache_resp_val)
					begin
						state <= arb_mem;
					end
				end
				arb_mem:
				begin
					arb_eqmem <= 1'b1;
					stall_mem <= 1'b0;
					if (mem_op_done && !dmem_pending)
					begin
						state     <= arb_instr;
						arb_eqmem <= 1'b0;  // Exit wins over the set above
					end
				end
				default:
				begin
					state <= arb_instr;  // Recover from the unused code
				end
			endcase
		end
	end

	// Store acked or load data returned while data owns the port
	assign dmem_finished = (state == arb_mem) && (cache_resp_val || cache_ack);

	// The two levels hand over on the same edge, never overlapping
	assert property (@(posedge clk) disable iff (!nrst)
		!(stall_mem && arb_eqmem))
		else $error("stall_mem and arb_eqmem both high");

	assert property (@(posedge clk) disable iff (!nrst)
		state inside {arb_instr, arb_wait, arb_mem})
		else $error("Arbiter state holds unused encoding");

endmodule

//--- req_mux.sv
`timescale 1ns/100ps

module req_mux (
	input arb_pkg::arb_state_t state,
	l15_req_if.arbiter         fetch_req,
	l15_req_if.arbiter         dmem_req,
	l15_req_if.cache           cache_req
);
	import arb_pkg::*;

	always_comb
	begin
		// Fetch connected unless overridden below
		cache_req.rqtype     = fetch_req.rqtype;
		cache_req.size       = fetch_req.size;
		cache_req.address    = fetch_req.address;
		cache_req.data       = fetch_req.data;
		cache_req.val        = fetch_req.val;
		fetch_req.ack        = cache_req.ack;
		fetch_req.header_ack = cache_req.header_ack;
		dmem_req.ack         = 1'b0;
		dmem_req.header_ack  = 1'b0;

		case (state)
			arb_wait:
			begin
				// No new request accepted, fetch may still see its ack
				cache_req.val        = 1'b0;
				fetch_req.header_ack = 1'b0;
			end
			arb_mem:
			begin
				cache_req.rqtype     = dmem_req.rqtype;
				cache_req.size       = dmem_req.size;
				cache_req.address    = dmem_req.address;
				cache_req.data       = dmem_req.data;
				cache_req.val        = dmem_req.val;
				fetch_req.ack        = 1'b0;
				fetch_req.header_ack = 1'b0;
				dmem_req.ack         = cache_req.ack;
				dmem_req.header_ack  = cache_req.header_ack;
			end
			default:
			begin
			end
		endcase
	end

	always_comb
	begin
		assert final (!(state == arb_wait && cache_req.val))
			else $error("Cache request valid while arbiter waits");
		assert final (!(state == arb_mem && fetch_req.header_ack) &&
			!(state != arb_mem && dmem_req.header_ack))
			else $error("header_ack reached a disconnected client");
	end

endmodule

//--- resp_router.sv
`timescale 1ns/100ps

module resp_router (
	input arb_pkg::arb_state_t state,
	l15_resp_if.client         cache_resp,
	l15_resp_if.cache          fetch_resp,
	l15_resp_if.cache          dmem_resp
);
	import arb_pkg::*;

	logic to_dmem;  // Data unit is the response owner

	assign to_dmem = (state == arb_mem);

	// Payload fans out to both, only the strobe is steered
	assign fetch_resp.data_0     = cache_resp.data_0;
	assign fetch_resp.data_1     = cache_resp.data_1;
	assign fetch_resp.returntype = cache_resp.returntype;
	assign dmem_resp.data_0      = cache_resp.data_0;
	assign dmem_resp.data_1      = cache_resp.data_1;
	assign dmem_resp.returntype  = cache_resp.returntype;

	// Fetch still owns responses in arb_wait
	assign fetch_resp.val = cache_resp.val && !to_dmem;
	assign dmem_resp.val  = cache_resp.val && to_dmem;

	assign cache_resp.req_ack = to_dmem ? dmem_resp.req_ack : fetch_resp.req_ack;

	always_comb
	begin
		assert final (!(fetch_resp.val && dmem_resp.val))
			else $error("Response strobe sent to both clients");
	end

endmodule

//--- cache_port_arbiter.sv
`timescale 1ns/100ps

module cache_port_arbiter (
	input  logic                 clk,
	input  logic                 nrst,

	// Fetch request and response
	input  l15_pkg::rqtype_t     fetch_rqtype,
	input  l15_pkg::rqsize_t     fetch_size,
	input  l15_pkg::l15_addr_t   fetch_address,
	input  l15_pkg::l15_data_t   fetch_data,
	input  logic                 fetch_val,
	output logic                 fetch_ack,
	output logic                 fetch_header_ack,
	output logic                 fetch_resp_val,
	output l15_pkg::l15_data_t   fetch_data_0,
	output l15_pkg::l15_data_t   fetch_data_1,
	output l15_pkg::returntype_t fetch_returntype,
	input  logic                 fetch_req_ack,

	// Data request and response
	input  l15_pkg::rqtype_t     dmem_rqtype,
	input  l15_pkg::rqsize_t     dmem_size,
	input  l15_pkg::l15_addr_t   dmem_address,
	input  l15_pkg::l15_data_t   dmem_data,
	input  logic                 dmem_val,
	output logic                 dmem_ack,
	output logic                 dmem_header_ack,
	output logic                 dmem_resp_val,
	output l15_pkg::l15_data_t   dmem_data_0,
	output l15_pkg::l15_data_t   dmem_data_1,
	output l15_pkg::returntype_t dmem_returntype,
	input  logic                 dmem_req_ack,

	// L1.5 request
	output l15_pkg::rqtype_t     transducer_l15_rqtype,
	output l15_pkg::rqsize_t     transducer_l15_size,
	output l15_pkg::l15_addr_t   transducer_l15_address,
	output l15_pkg::l15_data_t   transducer_l15_data,
	output logic                 transducer_l15_val,
	input  logic                 l15_transducer_ack,
	input  logic                 l15_transducer_header_ack,

	// L1.5 response
	input  logic                 l15_transducer_val,
	input  l15_pkg::l15_data_t   l15_transducer_data_0,
	input  l15_pkg::l15_data_t   l15_transducer_data_1,
	input  l15_pkg::returntype_t l15_transducer_returntype,
	output logic                 transducer_l15_req_ack,

	// Pipeline side
	input  logic                 dmem_pending,
	input  logic                 issue_hold,
	input  logic                 fetch_resp_phase,
	input  logic                 mem_op_done,
	output logic                 stall_mem,
	output logic                 arb_eqmem,
	output logic                 dmem_finished
);
	import arb_pkg::*;

	arb_state_t state;

	l15_req_if  fetch_req ();
	l15_req_if  dmem_req ();
	l15_req_if  cache_req ();
	l15_resp_if cache_resp ();
	l15_resp_if fetch_resp ();
	l15_resp_if dmem_resp ();

	assign fetch_req.rqtype  = fetch_rqtype;
	assign fetch_req.size    = fetch_size;
	assign fetch_req.address = fetch_address;
	assign fetch_req.data    = fetch_data;
	assign fetch_req.val     = fetch_val;
	assign fetch_ack         = fetch_req.ack;
	assign fetch_header_ack  = fetch_req.header_ack;

	assign dmem_req.rqtype  = dmem_rqtype;
	assign dmem_req.size    = dmem_size;
	assign dmem_req.address = dmem_address;
	assign dmem_req.data    = dmem_data;
	assign dmem_req.val     = dmem_val;
	assign dmem_ack         = dmem_req.ack;
	assign dmem_header_ack  = dmem_req.header_ack;

	assign transducer_l15_rqtype  = cache_req.rqtype;
	assign transducer_l15_size    = cache_req.size;
	assign transducer_l15_address = cache_req.address;
	assign transducer_l15_data    = cache_req.data;
	assign transducer_l15_val     = cache_req.val;
	assign cache_req.ack          = l15_transducer_ack;
	assign cache_req.header_ack   = l15_transducer_header_ack;

	assign cache_resp.val        = l15_transducer_val;
	assign cache_resp.data_0     = l15_transducer_data_0;
	assign cache_resp.data_1     = l15_transducer_data_1;
	assign cache_resp.returntype = l15_transducer_returntype;
	assign transducer_l15_req_ack = cache_resp.req_ack;

	assign fetch_resp_val     = fetch_resp.val;
	assign fetch_data_0       = fetch_resp.data_0;
	assign fetch_data_1       = fetch_resp.data_1;
	assign fetch_returntype   = fetch_resp.returntype;
	assign fetch_resp.req_ack = fetch_req_ack;

	assign dmem_resp_val     = dmem_resp.val;
	assign dmem_data_0       = dmem_resp.data_0;
	assign dmem_data_1       = dmem_resp.data_1;
	assign dmem_returntype   = dmem_resp.returntype;
	assign dmem_resp.req_ack = dmem_req_ack;

	arb_fsm i_arb_fsm (
		.clk              (clk),
		.nrst             (nrst),
		.dmem_pending     (dmem_pending),
		.issue_hold       (issue_hold),
		.fetch_resp_phase (fetch_resp_phase),
		.mem_op_done      (mem_op_done),
		.cache_resp_val   (l15_transducer_val),
		.cache_ack        (l15_transducer_ack),
		.state            (state),
		.stall_mem        (stall_mem),
		.arb_eqmem        (arb_eqmem),
		.dmem_finished    (dmem_finished)
	);

	req_mux i_req_mux (
		.state     (state),
		.fetch_req (fetch_req.arbiter),
		.dmem_req  (dmem_req.arbiter),
		.cache_req (cache_req.cache)
	);

	resp_router i_resp_router (
		.state      (state),
		.cache_resp (cache_resp.client),
		.fetch_resp (fetch_resp.cache),
		.dmem_resp  (dmem_resp.cache)
	);

endmodule

//--- tb_cache_port_arbiter.sv
`timescale 1ns/100ps

module tb_cache_port_arbiter;
	import l15_pkg::*;
	import arb_pkg::*;

	localparam int rounds     = 25;   // Full instr, wait, mem, instr trips
	localparam int wait_limit = 200;  // Cycles allowed per wait loop

	logic        clk;
	logic        nrst;
	rqtype_t     fetch_rqtype, dmem_rqtype, transducer_l15_rqtype;
	rqsize_t     fetch_size, dmem_size, transducer_l15_size;
	l15_addr_t   fetch_address, dmem_address, transducer_l15_address;
	l15_data_t   fetch_data, dmem_data, transducer_l15_data;
	logic        fetch_val, dmem_val, transducer_l15_val;
	logic        fetch_ack, fetch_header_ack, dmem_ack, dmem_header_ack;
	logic        fetch_resp_val, dmem_resp_val;
	l15_data_t   fetch_data_0, fetch_data_1, dmem_data_0, dmem_data_1;
	returntype_t fetch_returntype, dmem_returntype;
	logic        fetch_req_ack, dmem_req_ack, transducer_l15_req_ack;
	logic        l15_transducer_ack, l15_transducer_header_ack, l15_transducer_val;
	l15_data_t   l15_transducer_data_0, l15_transducer_data_1;
	returntype_t l15_transducer_returntype;
	logic        dmem_pending, issue_hold, fetch_resp_phase, mem_op_done;
	logic        stall_mem, arb_eqmem, dmem_finished;

	// Reference model registers
	arb_state_t  model_state;
	logic        model_stall;
	logic        model_eqmem;

	int          round;
	int          cycles;

	cache_port_arbiter i_cache_port_arbiter (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Transitions as the arbitration rules describe them
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			model_state <= arb_instr;
			model_stall <= 1'b0;
			model_eqmem <= 1'b0;
		end
		else if (model_state == arb_instr)
		begin
			if (dmem_pending && !issue_hold)
			begin
				model_state <= arb_wait;
				model_stall <= 1'b1;
			end
		end
		else if (model_state == arb_wait)
		begin
			if (fetch_resp_phase && l15_transducer_val)
				model_state <= arb_mem;
		end
		else
		begin
			model_stall <= 1'b0;
			model_eqmem <= !(mem_op_done && !dmem_pending);  // Clear on exit wins
			if (mem_op_done && !dmem_pending)
				model_state <= arb_instr;
		end
	end

	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %0h, got %0h",
				$time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s in round %0d",
			wait_limit, what, round);
		stop_with_failure();
	endtask

	task automatic drive_random();
		fetch_rqtype  = 5'($urandom);
		fetch_size    = 3'($urandom);
		fetch_address = $urandom;
		fetch_data    = {$urandom, $urandom};
		fetch_val     = ($urandom % 2) == 0;
		dmem_rqtype   = 5'($urandom);
		dmem_size     = 3'($urandom);
		dmem_address  = $urandom;
		dmem_data     = {$urandom, $urandom};
		dmem_val      = ($urandom % 2) == 0;
		fetch_req_ack = ($urandom % 2) == 0;
		dmem_req_ack  = ($urandom % 2) == 0;

		l15_transducer_ack        = ($urandom % 4) == 0;
		l15_transducer_header_ack = ($urandom % 4) == 0;
		l15_transducer_val        = ($urandom % 2) == 0;
		l15_transducer_data_0     = {$urandom, $urandom};
		l15_transducer_data_1     = {$urandom, $urandom};
		l15_transducer_returntype = 4'($urandom);

		// Fewer pending ops in arb_mem so the arbiter gets back to fetch
		if (model_state == arb_mem)
			dmem_pending = ($urandom % 4) == 0;
		else
			dmem_pending = ($urandom % 2) == 0;
		issue_hold       = ($urandom % 10) < 3;
		fetch_resp_phase = ($urandom % 2) == 0;
		mem_op_done      = ($urandom % 2) == 0;
	endtask

	task automatic check_outputs();
		logic to_dmem;
		logic to_fetch_ack;

		to_dmem      = (model_state == arb_mem);
		to_fetch_ack = (model_state != arb_mem);

		// Request side
		check_value("transducer_l15_rqtype", 64'(to_dmem ? dmem_rqtype : fetch_rqtype),
			64'(transducer_l15_rqtype));
		check_value("transducer_l15_size", 64'(to_dmem ? dmem_size : fetch_size),
			64'(transducer_l15_size));
		check_value("transducer_l15_address", 64'(to_dmem ? dmem_address : fetch_address),
			64'(transducer_l15_address));
		check_value("transducer_l15_data", to_dmem ? dmem_data : fetch_data,
			transducer_l15_data);
		check_value("transducer_l15_val",
			64'(to_dmem ? dmem_val : (model_state == arb_instr) && fetch_val),
			64'(transducer_l15_val));
		check_value("fetch_ack", 64'(to_fetch_ack && l15_transducer_ack), 64'(fetch_ack));
		check_value("fetch_header_ack",
			64'((model_state == arb_instr) && l15_transducer_header_ack),
			64'(fetch_header_ack));
		check_value("dmem_ack", 64'(to_dmem && l15_transducer_ack), 64'(dmem_ack));
		check_value("dmem_header_ack", 64'(to_dmem && l15_transducer_header_ack),
			64'(dmem_header_ack));

		// Response side with the payload sent to both clients
		check_value("fetch_resp_val", 64'(!to_dmem && l15_transducer_val),
			64'(fetch_resp_val));
		check_value("dmem_resp_val", 64'(to_dmem && l15_transducer_val), 64'(dmem_resp_val));
		check_value("fetch_data_0", l15_transducer_data_0, fetch_data_0);
		check_value("fetch_data_1", l15_transducer_data_1, fetch_data_1);
		check_value("fetch_returntype", 64'(l15_transducer_returntype),
			64'(fetch_returntype));
		check_value("dmem_data_0", l15_transducer_data_0, dmem_data_0);
		check_value("dmem_data_1", l15_transducer_data_1, dmem_data_1);
		check_value("dmem_returntype", 64'(l15_transducer_returntype), 64'(dmem_returntype));
		check_value("transducer_l15_req_ack", 64'(to_dmem ? dmem_req_ack : fetch_req_ack),
			64'(transducer_l15_req_ack));

		// Status levels
		check_value("stall_mem", 64'(model_stall), 64'(stall_mem));
		check_value("arb_eqmem", 64'(model_eqmem), 64'(arb_eqmem));
		check_value("dmem_finished",
			64'(to_dmem && (l15_transducer_val || l15_transducer_ack)), 64'(dmem_finished));
	endtask

	// New inputs on the falling edge and a check once outputs settle
	task automatic run_cycle(input logic release_reset);
		@(negedge clk);
		if (release_reset)
			nrst = 1'b1;
		drive_random();
		#1;
		check_outputs();
	endtask

	initial
	begin
		void'($urandom(32'h07de_b6c6));

		nrst                      = 1'b0;
		fetch_rqtype              = '0;
		fetch_size                = '0;
		fetch_address             = '0;
		fetch_data                = '0;
		fetch_val                 = 1'b0;
		fetch_req_ack             = 1'b0;
		dmem_rqtype               = '0;
		dmem_size                 = '0;
		dmem_address              = '0;
		dmem_data                 = '0;
		dmem_val                  = 1'b0;
		dmem_req_ack              = 1'b0;
		l15_transducer_ack        = 1'b0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_val        = 1'b0;
		l15_transducer_data_0     = '0;
		l15_transducer_data_1     = '0;
		l15_transducer_returntype = '0;
		dmem_pending              = 1'b0;
		issue_hold                = 1'b0;
		fetch_resp_phase          = 1'b0;
		mem_op_done               = 1'b0;

		repeat (9) run_cycle(1'b0);  // Model sits in arb_instr throughout
		run_cycle(1'b1);

		for (round = 0; round < rounds; round++)
		begin
			cycles = 0;
			while (model_state != arb_mem && cycles < wait_limit)
			begin
				run_cycle(1'b0);
				cycles++;
			end
			if (model_state != arb_mem)
				report_timeout("the data unit to own the port");

			cycles = 0;
			while (model_state != arb_instr && cycles < wait_limit)
			begin
				run_cycle(1'b0);
				cycles++;
			end
			if (model_state != arb_instr)
				report_timeout("fetch to own the port again");
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- list.f
l15_pkg.sv
arb_pkg.sv
l15_req_if.sv
l15_resp_if.sv
arb_fsm.sv
req_mux.sv
resp_router.sv
cache_port_arbiter.sv
tb_cache_port_arbiter.sv

//--- run.sh
#!/bin/bash
# Build and run the cache port arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_cache_port_arbiter \
	-o sim_tb > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "Testbench failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; } \
	|| { echo "Simulation finished without failure"; exit 0; }
